// File: source/kv_flush_cfg.svh
`ifndef KV_FLUSH_CFG_SVH
`define KV_FLUSH_CFG_SVH

// byte address width of the read masters
`define KV_ADDR_WIDTH 32

// table base of each dram bank
`define KV_BANK0_BASE 32'h0000_0000
`define KV_BANK1_BASE 32'h0010_0000

// one record per dram line, also the read length
`define KV_LINE_BYTES 32

`define KV_READER_FIFO_DEPTH 32
`define KV_OUT_FIFO_DEPTH 16

`endif

// File: source/kv_flush_pkg.sv
package kv_flush_pkg;

	// key sits in the upper half
	typedef struct packed {
		logic [31:0] key;
		logic [31:0] value;
	} kv_record_t;

	// record with the bank it was read from
	typedef struct packed {
		logic       bank;
		kv_record_t kv;
	} tagged_record_t;

endpackage

// File: source/kv_stream_if.sv
`timescale 1ns/1ps

// record stream from one flush reader to the merger
interface kv_stream_if;
	import kv_flush_pkg::*;

	kv_record_t record; // head of the reader fifo, valid while empty is low
	logic       empty;
	logic       drained; // reader idle and nothing left to hand over
	logic       pop;

	modport source (
		output record, empty, drained,
		input  pop
	);

	modport sink (
		input  record, empty, drained,
		output pop
	);

endinterface

// File: source/sync_fifo.sv
`timescale 1ns/1ps

// first word fall through buffer, head is always on rdata
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 16
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     write,
	input  payload_t wdata,
	input  logic     read,
	output payload_t rdata,
	output logic     empty,
	output logic     full
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_write;
	logic             do_read;

	// wraps at DEPTH so any depth works
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_write = write && !full;  // writes into a full fifo are dropped
	assign do_read  = read && !empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(DEPTH));
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(do_write) - CNT_W'(do_read);
		end
	end

endmodule

// File: source/dram_flush_reader.sv
`timescale 1ns/1ps
`include "kv_flush_cfg.svh"

// reads one bank's table line by line into a local record fifo
module dram_flush_reader #(
	parameter logic [`KV_ADDR_WIDTH-1:0] BASE = '0
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      flush,
	input  logic [31:0]               num_keys,
	output logic [`KV_ADDR_WIDTH-1:0] rd_base,
	output logic                      rd_go,
	input  logic                      rd_done,
	output logic                      rd_buffer_read,
	input  logic [255:0]              rd_data,
	input  logic                      rd_available,
	kv_stream_if.source               stream
);
	import kv_flush_pkg::*;

	typedef logic [`KV_ADDR_WIDTH-1:0] addr_t;

	typedef enum logic [2:0] {
		IDLE,
		START,
		WAIT_READ,
		CAPTURE,
		WRITE_FIFO
	} state_t;

	state_t      state;
	state_t      state_next;
	logic [31:0] key_count; // latched at the flush
	logic [31:0] key_count_next;
	logic [31:0] counter;   // lines captured so far
	logic [31:0] counter_next;
	addr_t       rd_base_next;
	logic        rd_go_next;
	kv_record_t  line_record;
	logic        fifo_write;
	logic        fifo_empty;
	logic        fifo_full;
	logic        read_open; // a line read is out at the master

	function automatic addr_t line_addr(input logic [31:0] index);
		return BASE + addr_t'(index) * addr_t'(`KV_LINE_BYTES);
	endfunction

	always_comb begin
		state_next     = state;
		key_count_next = key_count;
		counter_next   = counter;
		rd_base_next   = rd_base;
		rd_go_next     = 1'b0;
		case (state)
			IDLE: begin
				if (flush && num_keys != '0) begin // zero keys leaves the reader idle
					key_count_next = num_keys;
					counter_next   = '0;
					state_next     = START;
				end
			end
			START: begin
				rd_base_next = line_addr(counter);
				rd_go_next   = 1'b1;
				state_next   = WAIT_READ;
			end
			WAIT_READ: begin
				if (rd_available) begin
					state_next = CAPTURE;
				end
			end
			CAPTURE: begin
				counter_next = counter + 1;
				state_next   = WRITE_FIFO;
			end
			WRITE_FIFO: begin
				// hold the record until the fifo has room, no new read meanwhile
				if (!fifo_full) begin
					if (counter == key_count) begin
						state_next = IDLE;
					end else begin
						rd_base_next = line_addr(counter); // counter already points at the next line
						rd_go_next   = 1'b1;
						state_next   = WAIT_READ;
					end
				end
			end
			default: state_next = IDLE;
		endcase
	end

	assign rd_buffer_read = (state == WAIT_READ) && rd_available;
	assign fifo_write     = (state == WRITE_FIFO) && !fifo_full;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= IDLE;
			key_count <= '0;
			counter   <= '0;
			rd_base   <= '0;
			rd_go     <= 1'b0;
			read_open <= 1'b0;
		end else begin
			state     <= state_next;
			key_count <= key_count_next;
			counter   <= counter_next;
			rd_base   <= rd_base_next;
			rd_go     <= rd_go_next;
			if (rd_go) begin
				read_open <= 1'b1;
			end else if (rd_done || rd_buffer_read) begin
				read_open <= 1'b0;
			end
		end
	end

	// line data is taken the cycle after the buffer read, key goes on top
	always_ff @(posedge clk) begin
		if (state == CAPTURE) begin
			line_record.key   <= rd_data[31:0];
			line_record.value <= rd_data[63:32];
		end
	end

	sync_fifo #(
		.payload_t (kv_record_t),
		.DEPTH     (`KV_READER_FIFO_DEPTH)
	) record_fifo (
		.clk   (clk),
		.reset (reset),
		.write (fifo_write),
		.wdata (line_record),
		.read  (stream.pop),
		.rdata (stream.record),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	assign stream.empty   = fifo_empty;
	assign stream.drained = (state == IDLE) && fifo_empty && !read_open;

endmodule

// File: source/flush_merger.sv
`timescale 1ns/1ps
`include "kv_flush_cfg.svh"

// drains both reader streams round-robin into one tagged output fifo
module flush_merger (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         flush,
	kv_stream_if.sink                    bank0,
	kv_stream_if.sink                    bank1,
	output kv_flush_pkg::tagged_record_t out_record,
	input  logic                         out_read,
	output logic                         out_empty,
	output logic                         flush_done
);
	import kv_flush_pkg::*;

	logic           prefer; // stream tried first, flips after every pop
	logic           take0;
	logic           take1;
	logic           room;
	logic           out_write;
	logic           out_full;
	logic           active; // a flush was accepted and is not yet reported
	tagged_record_t out_wdata;

	// one pop in flight at most, so a write never lands on a full fifo
	assign room = !out_full && !out_write;

	always_comb begin
		take0 = 1'b0;
		take1 = 1'b0;
		if (room) begin
			if (prefer == 1'b0) begin
				take0 = !bank0.empty;
				take1 = bank0.empty && !bank1.empty;
			end else begin
				take1 = !bank1.empty;
				take0 = bank1.empty && !bank0.empty;
			end
		end
	end

	assign bank0.pop = take0;
	assign bank1.pop = take1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prefer    <= 1'b0;
			out_write <= 1'b0;
		end else begin
			out_write <= take0 || take1; // record lands in the fifo next cycle
			if (take0) begin
				prefer <= 1'b1;
			end else if (take1) begin
				prefer <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take0 || take1) begin
			out_wdata.bank <= take1;
			out_wdata.kv   <= take1 ? bank1.record : bank0.record;
		end
	end

	sync_fifo #(
		.payload_t (tagged_record_t),
		.DEPTH     (`KV_OUT_FIFO_DEPTH)
	) out_fifo (
		.clk   (clk),
		.reset (reset),
		.write (out_write),
		.wdata (out_wdata),
		.read  (out_read),
		.rdata (out_record),
		.empty (out_empty),
		.full  (out_full)
	);

	// done once everything has left through the output
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			active     <= 1'b0;
			flush_done <= 1'b0;
		end else if (flush) begin
			active     <= 1'b1;
			flush_done <= 1'b0;
		end else if (active && bank0.drained && bank1.drained && out_empty && !out_write) begin
			active     <= 1'b0;
			flush_done <= 1'b1;
		end
	end

endmodule

// File: source/kv_flush_top.sv
`timescale 1ns/1ps
`include "kv_flush_cfg.svh"

module kv_flush_top (
	input  logic                      clk,
	input  logic                      reset,

	// host side
	input  logic                      flush,
	input  logic [31:0]               num_keys0,
	input  logic [31:0]               num_keys1,
	output logic [31:0]               out_key,
	output logic [31:0]               out_value,
	output logic                      out_bank,
	output logic                      out_empty,
	input  logic                      out_read,
	output logic                      flush_done,

	// bank 0 read master
	output logic [`KV_ADDR_WIDTH-1:0] rd_base0,
	output logic                      rd_go0,
	input  logic                      rd_done0,
	output logic                      rd_buffer_read0,
	input  logic [255:0]              rd_data0,
	input  logic                      rd_available0,

	// bank 1 read master
	output logic [`KV_ADDR_WIDTH-1:0] rd_base1,
	output logic                      rd_go1,
	input  logic                      rd_done1,
	output logic                      rd_buffer_read1,
	input  logic [255:0]              rd_data1,
	input  logic                      rd_available1
);
	import kv_flush_pkg::*;

	tagged_record_t out_record;

	kv_stream_if stream0 ();
	kv_stream_if stream1 ();

	dram_flush_reader #(.BASE(`KV_BANK0_BASE)) reader0 (
		.clk            (clk),
		.reset          (reset),
		.flush          (flush),
		.num_keys       (num_keys0),
		.rd_base        (rd_base0),
		.rd_go          (rd_go0),
		.rd_done        (rd_done0),
		.rd_buffer_read (rd_buffer_read0),
		.rd_data        (rd_data0),
		.rd_available   (rd_available0),
		.stream         (stream0.source)
	);

	dram_flush_reader #(.BASE(`KV_BANK1_BASE)) reader1 (
		.clk            (clk),
		.reset          (reset),
		.flush          (flush),
		.num_keys       (num_keys1),
		.rd_base        (rd_base1),
		.rd_go          (rd_go1),
		.rd_done        (rd_done1),
		.rd_buffer_read (rd_buffer_read1),
		.rd_data        (rd_data1),
		.rd_available   (rd_available1),
		.stream         (stream1.source)
	);

	flush_merger merger (
		.clk        (clk),
		.reset      (reset),
		.flush      (flush),
		.bank0      (stream0.sink),
		.bank1      (stream1.sink),
		.out_record (out_record),
		.out_read   (out_read),
		.out_empty  (out_empty),
		.flush_done (flush_done)
	);

	assign out_bank  = out_record.bank;
	assign out_key   = out_record.kv.key;
	assign out_value = out_record.kv.value;

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ps

// free running clock, reset held over the first rising edges
module clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk); // release away from the active edge
		reset = 1'b0;
	end

endmodule

// File: bench/dram_bank_model.sv
`timescale 1ns/1ps
`include "kv_flush_cfg.svh"

// one dram bank behind a read master, line contents follow from the line index
module dram_bank_model #(
	parameter int unsigned               BANK      = 0,
	parameter logic [`KV_ADDR_WIDTH-1:0] BANK_BASE = '0
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`KV_ADDR_WIDTH-1:0] rd_base,
	input  logic                      rd_go,
	input  logic                      rd_buffer_read,
	output logic                      rd_done,
	output logic [255:0]              rd_data,
	output logic                      rd_available
);
	logic [`KV_ADDR_WIDTH-1:0] line_addr;
	logic [31:0]               index;
	logic [31:0]               key;
	logic [31:0]               value;
	int unsigned               delay;

	initial begin
		rd_done      = 1'b0;
		rd_available = 1'b0;
		rd_data      = '0;
		forever begin
			@(posedge clk);
			if (!reset && rd_go) begin
				line_addr = rd_base;
				index     = (line_addr - BANK_BASE) / `KV_LINE_BYTES;
				key       = BANK * 32'h0001_0000 + index;
				value     = key * 32'h9E37_79B1;
				delay     = $urandom_range(8, 1); // access latency of this line
				repeat (delay) @(negedge clk);
				// low word holds key then value, upper words repeat the address
				rd_data      = {{6{line_addr}}, value, key};
				rd_available = 1'b1;
				do @(posedge clk); while (!rd_buffer_read);
				@(negedge clk);
				rd_available = 1'b0; // data stays put for the capture cycle
				rd_done      = 1'b1;
				@(negedge clk);
				rd_done = 1'b0;
			end
		end
	end

endmodule

// File: bench/kv_flush_tb.sv
`timescale 1ns/1ps
`include "kv_flush_cfg.svh"

module kv_flush_tb;
	logic                      clk;
	logic                      reset;
	logic                      flush     = 1'b0;
	logic [31:0]               num_keys0 = '0;
	logic [31:0]               num_keys1 = '0;
	logic [31:0]               out_key;
	logic [31:0]               out_value;
	logic                      out_bank;
	logic                      out_empty;
	logic                      out_read  = 1'b0;
	logic                      flush_done;
	logic [`KV_ADDR_WIDTH-1:0] rd_base0;
	logic [`KV_ADDR_WIDTH-1:0] rd_base1;
	logic                      rd_go0;
	logic                      rd_go1;
	logic                      rd_done0;
	logic                      rd_done1;
	logic                      rd_buffer_read0;
	logic                      rd_buffer_read1;
	logic [255:0]              rd_data0;
	logic [255:0]              rd_data1;
	logic                      rd_available0;
	logic                      rd_available1;

	int unsigned expected_count [2];
	int unsigned next_index [2];    // next index expected from each bank
	int unsigned received_total = 0;
	int unsigned error_count    = 0;
	int unsigned failed_tests   = 0;
	int unsigned test_count     = 0;
	int unsigned quiet_cycles   = 0; // cycles without read master activity
	int unsigned budget_cycles  = 0;
	int unsigned rand_keys [8];
	bit          popping        = 1'b0;

	clock_gen clocks (.clk(clk), .reset(reset));

	dram_bank_model #(.BANK(0), .BANK_BASE(`KV_BANK0_BASE)) bank0 (
		.clk(clk), .reset(reset), .rd_base(rd_base0), .rd_go(rd_go0),
		.rd_buffer_read(rd_buffer_read0), .rd_done(rd_done0),
		.rd_data(rd_data0), .rd_available(rd_available0)
	);

	dram_bank_model #(.BANK(1), .BANK_BASE(`KV_BANK1_BASE)) bank1 (
		.clk(clk), .reset(reset), .rd_base(rd_base1), .rd_go(rd_go1),
		.rd_buffer_read(rd_buffer_read1), .rd_done(rd_done1),
		.rd_data(rd_data1), .rd_available(rd_available1)
	);

	kv_flush_top dut0 (.*);

	// key over value, as the table of each bank is laid out
	function automatic logic [63:0] ref_record(input int unsigned bank, input int unsigned index);
		logic [31:0] key;
		logic [31:0] value;
		key   = bank * 32'h0001_0000 + index;
		value = key * 32'h9E37_79B1;
		return {key, value};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
			error_count++;
		end
	endtask

	task automatic take_record();
		logic [63:0] expected;
		int          b;
		b = out_bank ? 1 : 0;
		if (next_index[b] >= expected_count[b]) begin
			$display("bank %0d sent a record beyond its key count of %0d at %0t",
				b, expected_count[b], $time);
			error_count++;
		end else begin
			expected = ref_record(b, next_index[b]);
			check_value("out_key", out_key, expected[63:32]);
			check_value("out_value", out_value, expected[31:0]);
		end
		next_index[b]++;
		received_total++;
	endtask

	// pops the output whenever allowed, the head is checked before it leaves
	always @(negedge clk) begin
		if (!reset && popping && !out_empty) begin
			take_record();
			out_read <= 1'b1;
		end else begin
			out_read <= 1'b0;
		end
	end

	always @(posedge clk) begin
		if (rd_go0 || rd_go1 || rd_available0 || rd_available1)
			quiet_cycles <= 0;
		else
			quiet_cycles <= quiet_cycles + 1;
	end

	task automatic report_test(input string name, input int unsigned errors_before);
		test_count++;
		if (error_count != errors_before)
			failed_tests++;
		$display("%s: %0d records, %0d errors", name, received_total, error_count - errors_before);
	endtask

	task automatic run_flush(input string name, input int unsigned keys0,
			input int unsigned keys1, input bit hold);
		int unsigned errors_before;
		errors_before = error_count;
		@(posedge clk);
		expected_count[0] = keys0;
		expected_count[1] = keys1;
		next_index[0]     = 0;
		next_index[1]     = 0;
		received_total    = 0;
		popping           = !hold;
		@(negedge clk);
		num_keys0 = keys0;
		num_keys1 = keys1;
		flush     = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		if (hold) begin
			repeat (4) @(negedge clk);
			while (quiet_cycles < 24) @(negedge clk); // all fifos full or reading finished
			check_value("flush_done", 32'(flush_done), 32'h0);
			check_value("out_empty", 32'(out_empty), 32'h0);
			@(posedge clk);
			popping = 1'b1;
		end
		while (!flush_done) @(negedge clk);
		repeat (2) @(negedge clk);
		check_value("out_empty", 32'(out_empty), 32'h1);
		for (int b = 0; b < 2; b++) begin
			check_value($sformatf("bank%0d_records", b), next_index[b], expected_count[b]);
		end
		report_test(name, errors_before);
	endtask

	initial begin
		int unsigned total_keys;
		int unsigned errors_before;
		void'($urandom(261));
		total_keys = 5 + 12 + 9 + 80;
		for (int i = 0; i < 8; i++) begin
			rand_keys[i] = $urandom_range(20, 0);
			total_keys += rand_keys[i];
		end
		budget_cycles = total_keys * 40 + 1000;

		@(negedge clk);
		while (reset) @(negedge clk);
		errors_before = error_count;
		check_value("out_empty", 32'(out_empty), 32'h1);
		check_value("flush_done", 32'(flush_done), 32'h0);
		check_value("rd_go0", 32'(rd_go0), 32'h0);
		check_value("rd_go1", 32'(rd_go1), 32'h0);
		report_test("after_reset", errors_before);

		run_flush("single_bank", 5, 0, 1'b0);
		run_flush("dual_bank", 12, 9, 1'b0);
		run_flush("back_pressure", 40, 40, 1'b1);
		run_flush("zero_keys", 0, 0, 1'b0);
		for (int i = 0; i < 4; i++)
			run_flush($sformatf("random_%0d", i), rand_keys[2*i], rand_keys[2*i+1], 1'b0);

		$display("%0d tests, %0d with errors, %0d errors in total",
			test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// budget of 40 cycles per key over all tests
	initial begin
		wait (budget_cycles != 0);
		repeat (budget_cycles) @(posedge clk);
		$display("run timed out after %0d cycles", budget_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/kv_flush_pkg.sv
source/kv_stream_if.sv
source/sync_fifo.sv
source/dram_flush_reader.sv
source/flush_merger.sv
source/kv_flush_top.sv
bench/clock_gen.sv
bench/dram_bank_model.sv
bench/kv_flush_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module kv_flush_tb -o kv_flush_sim

out=$(./obj_dir/kv_flush_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
